//--- verilog/clkrst_pkg.sv
// shared widths, link and channel counts
// register map addresses and field bit positions
package clkrst_pkg;

  ////////////////////////////////////////
  // bus and topology sizes
  ////////////////////////////////////////
  localparam int MM_DATA_W    = 64;
  localparam int MM_ADDR_W    = 10;
  localparam int N_LINKS      = 13;  // index 12 is the cross-link
  localparam int N_CORE_LINKS = 12;  // links with their own core reset bit
  localparam int N_CHAN       = 26;  // channel c sits on link c/2

  typedef logic [MM_DATA_W-1:0]    mm_data_t;
  typedef logic [MM_ADDR_W-1:0]    mm_addr_t;
  typedef logic [N_LINKS-1:0]      link_vec_t;
  typedef logic [N_CORE_LINKS-1:0] core_vec_t;
  typedef logic [N_CHAN-1:0]       chan_vec_t;

  ////////////////////////////////////////
  // register addresses
  ////////////////////////////////////////
  localparam mm_addr_t ADDR_SCRATCH   = 10'd0;
  localparam mm_addr_t ADDR_RSTCTRL_0 = 10'd1;
  localparam mm_addr_t ADDR_RSTCTRL_1 = 10'd2;
  localparam mm_addr_t ADDR_RSTSTATUS = 10'd3;  // read only
  localparam mm_addr_t ADDR_RXREADY   = 10'd4;  // read only

  ////////////////////////////////////////
  // field positions
  ////////////////////////////////////////
  localparam int RST0_LINK_LSB  = 0;   // 13 link resets
  localparam int RST0_PLL_BIT   = 16;
  localparam int RST0_CHIP_BIT  = 31;  // self clearing
  localparam int RST1_CORE_LSB  = 0;   // 12 core resets
  localparam int RST1_TX_LSB    = 16;  // 13 per-link tx resets
  localparam int RST1_RX_LSB    = 32;  // 13 per-link rx resets
  localparam int STAT_LOCK_BIT  = 0;   // synced pll lock
  localparam int STAT_CHIP_BIT  = 1;   // chip reset window
  localparam int RXRDY_LSB      = 0;   // 26 sticky rx ready flags

endpackage

//--- verilog/rst_ctrl_if.sv
// reset request fields and sticky rx ready status
// between register block and link reset generator
`timescale 1ns/1ps

interface rst_ctrl_if
  import clkrst_pkg::*;
();

  link_vec_t link_rst;         // whole-link reset, all domains of link
  core_vec_t core_rst;         // core-only reset, links 0..11
  link_vec_t tx_rst;           // serdes tx, both channels of link
  link_vec_t rx_rst;           // serdes rx, both channels of link
  chan_vec_t rx_ready_sticky;  // per channel, back to software

  // register side drives the levels, reads status back
  modport regs (
    output link_rst,
    output core_rst,
    output tx_rst,
    output rx_rst,
    input  rx_ready_sticky
  );

  // generator side consumes levels, owns sticky flags
  modport gen (
    input  link_rst,
    input  core_rst,
    input  tx_rst,
    input  rx_rst,
    output rx_ready_sticky
  );

endinterface

//--- verilog/clkrst_regs.sv
// memory-mapped reset control registers
// scratch, two control words, status and rx ready readback
// chip reset bit turns into a single-cycle request pulse
`timescale 1ns/1ps

module clkrst_regs
  import clkrst_pkg::*;
(
  input  logic     iCLK_SERDES_RXREC,
  input  logic     arst_n,
  input  logic     mm_wr_en,
  input  logic     mm_rd_en,
  input  mm_addr_t mm_addr,
  input  mm_data_t mm_wr_data,
  input  logic     chip_rst_active,  // from chip sequencer, status only
  input  logic     pll_locked_sync,
  output mm_data_t mm_rd_data,
  output logic     mm_rd_data_v,
  output logic     pll_rst,
  output logic     chip_rst_req,     // one cycle
  rst_ctrl_if.regs ctrl
);

  mm_data_t  scratch_q;
  link_vec_t link_rst_q;
  logic      pll_rst_q;
  logic      chip_req_q;
  core_vec_t core_rst_q;
  link_vec_t tx_rst_q;
  link_vec_t rx_rst_q;
  mm_data_t  rd_mux;

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////
  always_ff @(posedge iCLK_SERDES_RXREC or negedge arst_n)
  begin
    if (!arst_n)
    begin
      scratch_q  <= '0;
      link_rst_q <= '0;
      pll_rst_q  <= 1'b0;
      chip_req_q <= 1'b0;
      core_rst_q <= '0;
      tx_rst_q   <= '0;
      rx_rst_q   <= '0;
    end
    else
    begin
      chip_req_q <= 1'b0;  // self clear, pulse lasts one cycle
      if (mm_wr_en)
      begin
        case (mm_addr)
          ADDR_SCRATCH:   scratch_q <= mm_wr_data;
          ADDR_RSTCTRL_0:
          begin
            link_rst_q <= mm_wr_data[RST0_LINK_LSB +: N_LINKS];
            pll_rst_q  <= mm_wr_data[RST0_PLL_BIT];
            chip_req_q <= mm_wr_data[RST0_CHIP_BIT];
          end
          ADDR_RSTCTRL_1:
          begin
            core_rst_q <= mm_wr_data[RST1_CORE_LSB +: N_CORE_LINKS];
            tx_rst_q   <= mm_wr_data[RST1_TX_LSB +: N_LINKS];
            rx_rst_q   <= mm_wr_data[RST1_RX_LSB +: N_LINKS];
          end
          default: ;  // status words and holes ignore writes
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // read mux, unmapped reads zero
  ////////////////////////////////////////
  always_comb
  begin
    rd_mux = '0;
    case (mm_addr)
      ADDR_SCRATCH:   rd_mux = scratch_q;
      ADDR_RSTCTRL_0:
      begin
        rd_mux[RST0_LINK_LSB +: N_LINKS] = link_rst_q;
        rd_mux[RST0_PLL_BIT]             = pll_rst_q;  // chip bit stays 0
      end
      ADDR_RSTCTRL_1:
      begin
        rd_mux[RST1_CORE_LSB +: N_CORE_LINKS] = core_rst_q;
        rd_mux[RST1_TX_LSB +: N_LINKS]        = tx_rst_q;
        rd_mux[RST1_RX_LSB +: N_LINKS]        = rx_rst_q;
      end
      ADDR_RSTSTATUS:
      begin
        rd_mux[STAT_LOCK_BIT] = pll_locked_sync;
        rd_mux[STAT_CHIP_BIT] = chip_rst_active;
      end
      ADDR_RXREADY:   rd_mux[RXRDY_LSB +: N_CHAN] = ctrl.rx_ready_sticky;
      default: ;
    endcase
  end

  // read data lands one edge after rd_en
  always_ff @(posedge iCLK_SERDES_RXREC)
  begin
    if (mm_rd_en)
      mm_rd_data <= rd_mux;
  end

  always_ff @(posedge iCLK_SERDES_RXREC or negedge arst_n)
  begin
    if (!arst_n)
      mm_rd_data_v <= 1'b0;
    else
      mm_rd_data_v <= mm_rd_en;  // back to back reads pipeline
  end

  assign pll_rst       = pll_rst_q;
  assign chip_rst_req  = chip_req_q;
  assign ctrl.link_rst = link_rst_q;
  assign ctrl.core_rst = core_rst_q;
  assign ctrl.tx_rst   = tx_rst_q;
  assign ctrl.rx_rst   = rx_rst_q;

endmodule

//--- verilog/chip_rst_seq.sv
// pll lock synchronizer
// chip reset window counter, chip_ok output
`timescale 1ns/1ps

module chip_rst_seq #(
  parameter int SYNC_STAGES     = 3,
  parameter int CHIP_RST_CYCLES = 8
) (
  input  logic iCLK_SERDES_RXREC,
  input  logic arst_n,
  input  logic chip_rst_req,    // pulse from register block
  input  logic pll_locked,      // async, straight from pll
  output logic pll_locked_sync,
  output logic chip_rst_active,
  output logic chip_ok
);

  localparam int CNT_W = $clog2(CHIP_RST_CYCLES + 1);

  logic [SYNC_STAGES-1:0] lock_sr;
  logic [CNT_W-1:0]       win_cnt;

  ////////////////////////////////////////
  // lock sync
  ////////////////////////////////////////
  always_ff @(posedge iCLK_SERDES_RXREC or negedge arst_n)
  begin
    if (!arst_n)
      lock_sr <= '0;
    else
      lock_sr <= (lock_sr << 1) | SYNC_STAGES'(pll_locked);  // shift in at bit 0
  end

  assign pll_locked_sync = lock_sr[SYNC_STAGES-1];

  ////////////////////////////////////////
  // chip reset window
  ////////////////////////////////////////
  always_ff @(posedge iCLK_SERDES_RXREC or negedge arst_n)
  begin
    if (!arst_n)
      win_cnt <= '0;
    else if (chip_rst_req)
      win_cnt <= CNT_W'(CHIP_RST_CYCLES);  // new request restarts window
    else if (win_cnt != '0)
      win_cnt <= win_cnt - CNT_W'(1);
  end

  assign chip_rst_active = (win_cnt != '0);  // high for CHIP_RST_CYCLES edges
  assign chip_ok         = ~chip_rst_active;

endmodule

//--- verilog/link_rst_gen.sv
// per link and per channel reset release logic
// async assert / sync deassert synchronizers
// rx ready sync and sticky flag per channel
`timescale 1ns/1ps

module link_rst_gen
  import clkrst_pkg::*;
#(
  parameter int SYNC_STAGES = 3
) (
  input  logic      iCLK_SERDES_RXREC,
  input  logic      arst_n,
  input  logic      chip_ok,
  input  logic      pll_locked_sync,
  input  chan_vec_t atx_pll_locked,   // async, per channel
  input  chan_vec_t rx_ready,         // async, may flap without signal
  output link_vec_t link_core_rst_n,
  output chan_vec_t link_tx_rst_n,
  output chan_vec_t link_rx_rst_n,
  output logic      core_rst_n,
  rst_ctrl_if.gen   ctrl
);

  // core x13, tx x26, rx x26, chip-level core x1
  localparam int N_RST  = N_LINKS + 2 * N_CHAN + 1;
  localparam int TX_OFS = N_LINKS;
  localparam int RX_OFS = N_LINKS + N_CHAN;

  link_vec_t        core_rel;  // 1 = release
  chan_vec_t        tx_rel;
  chan_vec_t        rx_rel;
  logic [N_RST-1:0] rel;
  logic [N_RST-1:0] rst_out;
  chan_vec_t        sticky;

  ////////////////////////////////////////
  // release terms
  ////////////////////////////////////////
  // cross-link has no core bit, zero-extend
  assign core_rel = ~(link_vec_t'(ctrl.core_rst) | ctrl.link_rst)
                    & {N_LINKS{chip_ok & pll_locked_sync}};

  for (genvar c = 0; c < N_CHAN; c++)
  begin : g_chan_rel
    localparam int  LNK   = c / 2;
    localparam bit  XLINK = (LNK == N_LINKS - 1);  // ch 24/25 skip atx lock
    assign tx_rel[c] = ~ctrl.tx_rst[LNK] & ~ctrl.link_rst[LNK] & chip_ok
                       & (atx_pll_locked[c] | XLINK);
    assign rx_rel[c] = ~ctrl.rx_rst[LNK] & ~ctrl.link_rst[LNK] & chip_ok;
  end

  assign rel = {chip_ok & pll_locked_sync, rx_rel, tx_rel, core_rel};

  ////////////////////////////////////////
  // reset synchronizers
  ////////////////////////////////////////
  for (genvar i = 0; i < N_RST; i++)
  begin : g_rst_sync
    logic                   clr_n;
    logic [SYNC_STAGES-1:0] sr;
    assign clr_n = rel[i] & arst_n;  // assert immediately
    always_ff @(posedge iCLK_SERDES_RXREC or negedge clr_n)
    begin
      if (!clr_n)
        sr <= '0;
      else
        sr <= (sr << 1) | SYNC_STAGES'(1);  // release walks through stages
    end
    assign rst_out[i] = sr[SYNC_STAGES-1];
  end

  assign link_core_rst_n = rst_out[0 +: N_LINKS];
  assign link_tx_rst_n   = rst_out[TX_OFS +: N_CHAN];
  assign link_rx_rst_n   = rst_out[RX_OFS +: N_CHAN];
  assign core_rst_n      = rst_out[N_RST-1];

  ////////////////////////////////////////
  // sticky rx ready
  ////////////////////////////////////////
  // first assertion sets, only the channel's rx reset clears
  // keeps a flapping cdr from bouncing the rx reset
  for (genvar c = 0; c < N_CHAN; c++)
  begin : g_rx_ready
    logic [SYNC_STAGES-1:0] rdy_sr;
    logic                   sticky_q;
    always_ff @(posedge iCLK_SERDES_RXREC or negedge arst_n)
    begin
      if (!arst_n)
        rdy_sr <= '0;
      else
        rdy_sr <= (rdy_sr << 1) | SYNC_STAGES'(rx_ready[c]);
    end
    always_ff @(posedge iCLK_SERDES_RXREC or negedge link_rx_rst_n[c])
    begin
      if (!link_rx_rst_n[c])
        sticky_q <= 1'b0;
      else if (rdy_sr[SYNC_STAGES-1])
        sticky_q <= 1'b1;  // hold until rx reset
    end
    assign sticky[c] = sticky_q;
  end

  assign ctrl.rx_ready_sticky = sticky;

endmodule

//--- verilog/clkrst_top.sv
// reset management top, single serdes rx recovered clock
// register block, chip sequencer, link reset generator
`timescale 1ns/1ps

module clkrst_top
  import clkrst_pkg::*;
#(
  parameter int SYNC_STAGES     = 3,
  parameter int CHIP_RST_CYCLES = 8
) (
  input  logic      iCLK_SERDES_RXREC,
  input  logic      arst_n,
  // mm register bus
  input  logic      mm_wr_en,
  input  logic      mm_rd_en,
  input  mm_addr_t  mm_addr,
  input  mm_data_t  mm_wr_data,
  output mm_data_t  mm_rd_data,
  output logic      mm_rd_data_v,
  // lock and ready from pll / serdes
  input  logic      pll_locked,
  input  chan_vec_t atx_pll_locked,
  input  chan_vec_t rx_ready,
  // reset outputs, active low except pll_rst
  output logic      pll_rst,
  output logic      core_rst_n,
  output link_vec_t link_core_rst_n,
  output chan_vec_t link_tx_rst_n,
  output chan_vec_t link_rx_rst_n
);

  logic chip_rst_req;
  logic chip_rst_active;
  logic chip_ok;
  logic pll_locked_sync;

  rst_ctrl_if u_ctrl_if ();

  clkrst_regs u_regs (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .arst_n            (arst_n),
    .mm_wr_en          (mm_wr_en),
    .mm_rd_en          (mm_rd_en),
    .mm_addr           (mm_addr),
    .mm_wr_data        (mm_wr_data),
    .chip_rst_active   (chip_rst_active),
    .pll_locked_sync   (pll_locked_sync),
    .mm_rd_data        (mm_rd_data),
    .mm_rd_data_v      (mm_rd_data_v),
    .pll_rst           (pll_rst),
    .chip_rst_req      (chip_rst_req),
    .ctrl              (u_ctrl_if.regs)
  );

  chip_rst_seq #(
    .SYNC_STAGES     (SYNC_STAGES),
    .CHIP_RST_CYCLES (CHIP_RST_CYCLES)
  ) u_chip_seq (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .arst_n            (arst_n),
    .chip_rst_req      (chip_rst_req),
    .pll_locked        (pll_locked),
    .pll_locked_sync   (pll_locked_sync),
    .chip_rst_active   (chip_rst_active),
    .chip_ok           (chip_ok)
  );

  link_rst_gen #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_link_gen (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .arst_n            (arst_n),
    .chip_ok           (chip_ok),
    .pll_locked_sync   (pll_locked_sync),
    .atx_pll_locked    (atx_pll_locked),
    .rx_ready          (rx_ready),
    .link_core_rst_n   (link_core_rst_n),
    .link_tx_rst_n     (link_tx_rst_n),
    .link_rx_rst_n     (link_rx_rst_n),
    .core_rst_n        (core_rst_n),
    .ctrl              (u_ctrl_if.gen)
  );

endmodule

//--- bench/clkrst_asserts.sv
// bound checks on read valid timing and reset dominance
`timescale 1ns/1ps

module clkrst_asserts
  import clkrst_pkg::*;
(
  input logic      iCLK_SERDES_RXREC,
  input logic      arst_n,
  input logic      mm_rd_en,
  input logic      mm_rd_data_v,
  input logic      chip_ok,
  input logic      pll_locked_sync,
  input logic      core_rst_n,
  input link_vec_t link_core_rst_n,
  input chan_vec_t link_tx_rst_n,
  input chan_vec_t link_rx_rst_n
);

  // valid is rd_en one edge later
  a_rd_valid: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!arst_n)
    mm_rd_data_v == $past(mm_rd_en))
    else $error("read data valid did not follow read enable by one cycle");

  // chip window holds everything
  a_chip_win: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!arst_n)
    !chip_ok |-> (!core_rst_n && link_core_rst_n == '0
                  && link_tx_rst_n == '0 && link_rx_rst_n == '0))
    else $error("reset output released during chip reset window");

  a_pll_lock: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!arst_n)
    !pll_locked_sync |-> (!core_rst_n && link_core_rst_n == '0))
    else $error("core reset released without pll lock");

endmodule

bind clkrst_top clkrst_asserts u_asserts (
  .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
  .arst_n            (arst_n),
  .mm_rd_en          (mm_rd_en),
  .mm_rd_data_v      (mm_rd_data_v),
  .chip_ok           (chip_ok),
  .pll_locked_sync   (pll_locked_sync),
  .core_rst_n        (core_rst_n),
  .link_core_rst_n   (link_core_rst_n),
  .link_tx_rst_n     (link_tx_rst_n),
  .link_rx_rst_n     (link_rx_rst_n)
);

//--- bench/tb_clkrst.sv
// testbench for the reset management top
// bus write/read tasks, reference reset model, comparison process
// per-test reporting and closing counts
`timescale 1ns/1ps

module tb_clkrst
  import clkrst_pkg::*;
();

  localparam int SYNC_STAGES     = 3;
  localparam int CHIP_RST_CYCLES = 8;
  localparam int SETTLE          = 2 * SYNC_STAGES + 2;  // lock sync, then reset sync
  localparam int TIMEOUT_CYCLES  = 2000;  // six tests well under 200 cycles each
  localparam mm_data_t MASK0     = 64'h0000_0000_0001_1fff;  // link resets, pll reset
  localparam mm_data_t MASK1     = 64'h0000_1fff_1fff_0fff;  // core, tx, rx

  logic      iCLK_SERDES_RXREC = 1'b0;
  logic      arst_n;
  logic      mm_wr_en;
  logic      mm_rd_en;
  mm_addr_t  mm_addr;
  mm_data_t  mm_wr_data;
  mm_data_t  mm_rd_data;
  logic      mm_rd_data_v;
  logic      pll_locked;
  chan_vec_t atx_pll_locked;
  chan_vec_t rx_ready;
  logic      pll_rst;
  logic      core_rst_n;
  link_vec_t link_core_rst_n;
  chan_vec_t link_tx_rst_n;
  chan_vec_t link_rx_rst_n;

  mm_data_t  sh0;      // shadow of RSTCTRL_0
  mm_data_t  sh1;      // shadow of RSTCTRL_1
  mm_data_t  scratch;
  chan_vec_t exp_rdy;  // expected sticky flags
  int        seed;
  int        cycles    = 0;
  int        checks    = 0;
  int        errors    = 0;
  int        test_err  = 0;
  int        tests_ok  = 0;
  int        tests_bad = 0;
  event      check_req;
  event      check_done;

  clkrst_top u_dut (.*);

  always #5 iCLK_SERDES_RXREC = ~iCLK_SERDES_RXREC;

  always @(posedge iCLK_SERDES_RXREC)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, test sequence did not complete", cycles);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // {core_rst_n, rx[25:0], tx[25:0], link_core[12:0]}, 1 = released
  function automatic logic [65:0] expected_resets(mm_data_t r0, mm_data_t r1, logic win,
                                                  logic lock, chan_vec_t atx);
    link_vec_t core;
    chan_vec_t tx;
    chan_vec_t rx;
    int        l;
    for (int j = 0; j < N_LINKS; j++)
      core[j] = !(j < N_CORE_LINKS && r1[RST1_CORE_LSB + j]) && !r0[j] && !win && lock;
    for (int c = 0; c < N_CHAN; c++)
    begin
      l = c / 2;
      // cross-link channels ignore atx lock
      tx[c] = !r1[RST1_TX_LSB + l] && !r0[l] && !win && (atx[c] || l == N_LINKS - 1);
      rx[c] = !r1[RST1_RX_LSB + l] && !r0[l] && !win;
    end
    return {!win && lock, rx, tx, core};
  endfunction

  function automatic logic [65:0] reset_outputs();
    return {core_rst_n, link_rx_rst_n, link_tx_rst_n, link_core_rst_n};
  endfunction

  task automatic expect_eq(string name, logic [65:0] got, logic [65:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // compare process, waits out both sync chains then samples mid-cycle
  always
  begin
    @(check_req);
    repeat (SETTLE) @(posedge iCLK_SERDES_RXREC);
    @(negedge iCLK_SERDES_RXREC);
    expect_eq("resets {core_rst_n,rx,tx,link_core}", reset_outputs(),
              expected_resets(sh0, sh1, 1'b0, pll_locked, atx_pll_locked));
    expect_eq("pll_rst", {65'b0, pll_rst}, {65'b0, sh0[RST0_PLL_BIT]});
    -> check_done;
  end

  task automatic run_check();
    -> check_req;
    @(check_done);
  endtask

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////
  task automatic mm_write(mm_addr_t addr, mm_data_t data);
    @(negedge iCLK_SERDES_RXREC);
    mm_wr_en   = 1'b1;
    mm_addr    = addr;
    mm_wr_data = data;
    @(negedge iCLK_SERDES_RXREC);
    mm_wr_en   = 1'b0;
  endtask

  task automatic mm_read(mm_addr_t addr, output mm_data_t data);
    @(negedge iCLK_SERDES_RXREC);
    mm_rd_en = 1'b1;
    mm_addr  = addr;
    @(negedge iCLK_SERDES_RXREC);
    mm_rd_en = 1'b0;
    expect_eq("mm_rd_data_v", {65'b0, mm_rd_data_v}, 66'd1);  // one edge after rd_en
    data     = mm_rd_data;
  endtask

  task automatic read_expect(mm_addr_t addr, mm_data_t exp, string name);
    mm_data_t rd;
    mm_read(addr, rd);
    expect_eq(name, {2'b0, rd}, {2'b0, exp});
  endtask

  task automatic end_test(string name);
    if (errors == test_err)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - test_err);
    end
    test_err = errors;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial
  begin
    logic [31:0] rnd;
    int          k;
    int          j;
    arst_n         = 1'b0;
    mm_wr_en       = 1'b0;
    mm_rd_en       = 1'b0;
    mm_addr        = '0;
    mm_wr_data     = '0;
    pll_locked     = 1'b1;
    atx_pll_locked = '1;
    rx_ready       = '0;
    seed           = 32'h3a6b9cd0;
    sh0            = '0;
    sh1            = '0;
    exp_rdy        = '0;
    repeat (16) @(negedge iCLK_SERDES_RXREC);
    arst_n = 1'b1;

    // reset defaults
    run_check();
    read_expect(ADDR_RSTCTRL_0, '0, "RSTCTRL_0");
    read_expect(ADDR_RSTCTRL_1, '0, "RSTCTRL_1");
    read_expect(ADDR_RSTSTATUS, 64'h1, "RSTSTATUS");  // lock only
    end_test("reset defaults");

    // scratch, then a back-to-back pair ending on an unmapped address
    for (int i = 0; i < 4; i++)
    begin
      scratch = {$random(seed), $random(seed)};
      mm_write(ADDR_SCRATCH, scratch);
      read_expect(ADDR_SCRATCH, scratch, "scratch");
    end
    @(negedge iCLK_SERDES_RXREC);
    mm_rd_en = 1'b1;
    mm_addr  = ADDR_SCRATCH;
    @(negedge iCLK_SERDES_RXREC);
    mm_addr  = 10'h3ff;  // second read in flight
    expect_eq("mm_rd_data_v", {65'b0, mm_rd_data_v}, 66'd1);
    expect_eq("mm_rd_data", {2'b0, mm_rd_data}, {2'b0, scratch});
    @(negedge iCLK_SERDES_RXREC);
    mm_rd_en = 1'b0;
    expect_eq("mm_rd_data_v", {65'b0, mm_rd_data_v}, 66'd1);
    expect_eq("mm_rd_data", {2'b0, mm_rd_data}, 66'd0);
    end_test("scratch readback");

    // random control words and atx lock vectors
    for (int i = 0; i < 8; i++)
    begin
      sh0 = {$random(seed), $random(seed)} & MASK0;
      sh1 = {$random(seed), $random(seed)} & MASK1;
      rnd = $random(seed);
      atx_pll_locked = rnd[N_CHAN-1:0];
      mm_write(ADDR_RSTCTRL_0, sh0);
      mm_write(ADDR_RSTCTRL_1, sh1);
      run_check();
      read_expect(ADDR_RSTCTRL_1, sh1, "RSTCTRL_1");
    end
    atx_pll_locked = '1;
    sh0 = '0;
    sh1 = '0;
    mm_write(ADDR_RSTCTRL_0, sh0);
    mm_write(ADDR_RSTCTRL_1, sh1);
    run_check();
    end_test("random control");

    // lock gating, one random channel plus cross-link channel 25
    pll_locked = 1'b0;
    run_check();
    k = {$random(seed)} % N_CHAN;
    pll_locked = 1'b1;
    atx_pll_locked = ~((chan_vec_t'(1) << k) | (chan_vec_t'(1) << 25));
    run_check();
    atx_pll_locked = '1;
    run_check();
    end_test("lock gating");

    // chip reset window
    sh0 = mm_data_t'(1) << RST0_PLL_BIT;
    mm_write(ADDR_RSTCTRL_0, sh0 | (mm_data_t'(1) << RST0_CHIP_BIT));
    @(posedge iCLK_SERDES_RXREC);  // window opens here
    @(negedge iCLK_SERDES_RXREC);
    expect_eq("resets in chip window", reset_outputs(),
              expected_resets(sh0, sh1, 1'b1, pll_locked, atx_pll_locked));
    // status read every cycle, count edges that see the window
    mm_rd_en = 1'b1;
    mm_addr  = ADDR_RSTSTATUS;
    k        = 0;
    do
    begin
      @(negedge iCLK_SERDES_RXREC);
      if (mm_rd_data[STAT_CHIP_BIT])
        k++;
    end
    while (mm_rd_data[STAT_CHIP_BIT]);
    mm_rd_en = 1'b0;
    expect_eq("chip window length", 66'(k), 66'(CHIP_RST_CYCLES));
    read_expect(ADDR_RSTSTATUS, 64'h1, "RSTSTATUS");  // window closed, lock only
    read_expect(ADDR_RSTCTRL_0, sh0, "RSTCTRL_0");  // chip bit self clears
    run_check();
    end_test("chip reset");

    // sticky rx ready on two links, then clear one link
    k = {$random(seed)} % N_CHAN;
    j = (k + 4) % N_CHAN;
    rx_ready = (chan_vec_t'(1) << k) | (chan_vec_t'(1) << j);
    @(negedge iCLK_SERDES_RXREC);
    rx_ready = '0;
    exp_rdy  = (chan_vec_t'(1) << k) | (chan_vec_t'(1) << j);
    run_check();
    read_expect(ADDR_RXREADY, {38'b0, exp_rdy}, "RXREADY");
    sh1 = mm_data_t'(1) << (RST1_RX_LSB + k / 2);
    mm_write(ADDR_RSTCTRL_1, sh1);
    exp_rdy = exp_rdy & ~(chan_vec_t'(3) << (2 * (k / 2)));  // both channels of link
    run_check();
    read_expect(ADDR_RXREADY, {38'b0, exp_rdy}, "RXREADY");
    sh1 = '0;
    mm_write(ADDR_RSTCTRL_1, sh1);
    run_check();
    read_expect(ADDR_RXREADY, {38'b0, exp_rdy}, "RXREADY");
    end_test("sticky rx ready");

    $display("tests ok %0d, tests failed %0d, checks %0d, errors %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- build.f
verilog/clkrst_pkg.sv
verilog/rst_ctrl_if.sv
verilog/clkrst_regs.sv
verilog/chip_rst_seq.sv
verilog/link_rst_gen.sv
verilog/clkrst_top.sv
bench/clkrst_asserts.sv
bench/tb_clkrst.sv

//--- Makefile
# Verilator build and run of the reset management testbench

VERILATOR ?= verilator
TOP       ?= tb_clkrst
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
